// File: Bender.yml
package:
  name: io_hub

sources:
  - include_dirs:
      - design
    files:
      - design/io_hub_pkg.sv
      - design/io_bus_ctrl.sv
      - design/port_decode.sv
      - design/pit_timer.sv
      - design/pic_ctrl.sv
      - design/io_hub.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/io_hub_properties.sv
      - test/io_hub_tb.sv

// File: design/io_bus_ctrl.sv
`timescale 1ns/1ps

module io_bus_ctrl (
	input  logic                  clk_sys,
	input  logic                  rst_n,

	input  logic                  io_read_do,
	input  io_hub_pkg::io_addr_t  io_read_address,
	output io_hub_pkg::io_data_t  io_read_data,
	output logic                  io_read_done,

	input  logic                  io_write_do,
	input  io_hub_pkg::io_addr_t  io_write_address,
	input  io_hub_pkg::io_data_t  io_write_data,
	output logic                  io_write_done,

	output io_hub_pkg::io_addr_t  bus_address,
	output io_hub_pkg::io_data_t  bus_writedata,
	output logic                  bus_read,
	output logic                  bus_write,
	input  io_hub_pkg::io_data_t  bus_readdata
);
	import io_hub_pkg::*;

	bus_state_t state;
	logic       is_write;   // channel being served
	logic       resp_sent;  // done already pulsed in RESPOND
	logic       chan_do;

	assign chan_do   = is_write ? io_write_do : io_read_do;

	// strobes live only in ACCESS
	assign bus_read  = (state == ACCESS) && !is_write;
	assign bus_write = (state == ACCESS) && is_write;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state         <= IDLE;
			is_write      <= 1'b0;
			resp_sent     <= 1'b0;
			io_read_done  <= 1'b0;
			io_write_done <= 1'b0;
		end else begin
			io_read_done  <= 1'b0;
			io_write_done <= 1'b0;
			case (state)
				IDLE: begin
					if (io_read_do) begin // read wins a tie
						is_write <= 1'b0;
						state    <= DECODE;
					end else if (io_write_do) begin
						is_write <= 1'b1;
						state    <= DECODE;
					end
				end
				DECODE: state <= ACCESS; // selects settle
				ACCESS: begin
					resp_sent <= 1'b0;
					state     <= RESPOND;
				end
				RESPOND: begin
					if (!resp_sent) begin
						resp_sent     <= 1'b1;
						io_read_done  <= !is_write;
						io_write_done <= is_write;
					end else if (!chan_do) begin
						state <= IDLE; // cpu has let go
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// address, data and read byte
	always_ff @(posedge clk_sys) begin
		if (state == IDLE) begin
			if (io_read_do) begin
				bus_address <= io_read_address;
			end else if (io_write_do) begin
				bus_address   <= io_write_address;
				bus_writedata <= io_write_data;
			end
		end
		if (state == RESPOND && !resp_sent && !is_write) begin
			io_read_data <= bus_readdata;
		end
	end

endmodule

// File: design/io_hub.sv
`timescale 1ns/1ps

module io_hub (
	input  logic                  clk_sys,
	input  logic                  rst_n,

	input  logic                  io_read_do,
	input  io_hub_pkg::io_addr_t  io_read_address,
	output io_hub_pkg::io_data_t  io_read_data,
	output logic                  io_read_done,

	input  logic                  io_write_do,
	input  io_hub_pkg::io_addr_t  io_write_address,
	input  io_hub_pkg::io_data_t  io_write_data,
	output logic                  io_write_done,

	input  logic [6:0]            irq_ext,
	output logic                  interrupt_do,
	output io_hub_pkg::irq_vec_t  interrupt_vector,
	input  logic                  interrupt_done
);

	io_hub_pkg::io_addr_t bus_address;
	io_hub_pkg::io_data_t bus_writedata;
	io_hub_pkg::io_data_t bus_readdata;
	logic                 bus_read;
	logic                 bus_write;

	logic                 pit_cs;
	logic                 pic_cs;
	io_hub_pkg::io_data_t pit_readdata;
	io_hub_pkg::io_data_t pic_readdata;
	logic                 pit_irq;

	wire io_hub_pkg::irq_lines_t irq_lines = {irq_ext, pit_irq}; // timer owns line 0

	io_bus_ctrl bus_ctrl_i (
		.clk_sys          (clk_sys),
		.rst_n            (rst_n),
		.io_read_do       (io_read_do),
		.io_read_address  (io_read_address),
		.io_read_data     (io_read_data),
		.io_read_done     (io_read_done),
		.io_write_do      (io_write_do),
		.io_write_address (io_write_address),
		.io_write_data    (io_write_data),
		.io_write_done    (io_write_done),
		.bus_address      (bus_address),
		.bus_writedata    (bus_writedata),
		.bus_read         (bus_read),
		.bus_write        (bus_write),
		.bus_readdata     (bus_readdata)
	);

	port_decode decode_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.bus_address  (bus_address),
		.pit_readdata (pit_readdata),
		.pic_readdata (pic_readdata),
		.pit_cs       (pit_cs),
		.pic_cs       (pic_cs),
		.bus_readdata (bus_readdata)
	);

	pit_timer pit_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.pit_cs        (pit_cs),
		.bus_read      (bus_read),
		.bus_write     (bus_write),
		.bus_writedata (bus_writedata),
		.pit_readdata  (pit_readdata),
		.pit_irq       (pit_irq)
	);

	pic_ctrl pic_i (
		.clk_sys          (clk_sys),
		.rst_n            (rst_n),
		.pic_cs           (pic_cs),
		.bus_read         (bus_read),
		.bus_write        (bus_write),
		.bus_address0     (bus_address[0]),
		.bus_writedata    (bus_writedata),
		.irq_lines        (irq_lines),
		.interrupt_done   (interrupt_done),
		.pic_readdata     (pic_readdata),
		.interrupt_do     (interrupt_do),
		.interrupt_vector (interrupt_vector)
	);

endmodule

// File: design/io_hub_config.svh
`ifndef IO_HUB_CONFIG_SVH
`define IO_HUB_CONFIG_SVH

// i/o port map
`define IO_HUB_PIC_BASE       16'h0020 // +0 pending, +1 mask
`define IO_HUB_PIT_PORT       16'h0040
`define IO_HUB_UNMAPPED_DATA  8'hFF    // floating bus reads high

// timer clocking
`define IO_HUB_PIT_PRESCALE   4        // clk_sys cycles per count
`define IO_HUB_PIT_PRESCALE_W 2        // must hold PRESCALE-1

// interrupt controller
`define IO_HUB_VECTOR_BASE    8'h08    // vector of line 0
`define IO_HUB_PIC_MASK_INIT  8'hFF    // all lines masked out of reset

`endif

// File: design/io_hub_pkg.sv
package io_hub_pkg;

	typedef logic [15:0] io_addr_t;   // i/o port address
	typedef logic [7:0]  io_data_t;
	typedef logic [7:0]  irq_vec_t;
	typedef logic [7:0]  irq_lines_t; // bit n is line n
	typedef logic [15:0] pit_count_t;

	// cpu request sequencing
	typedef enum logic [1:0] {
		IDLE,
		DECODE,
		ACCESS,
		RESPOND
	} bus_state_t;

endpackage

// File: design/pic_ctrl.sv
`timescale 1ns/1ps

`include "io_hub_config.svh"

module pic_ctrl (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    pic_cs,
	input  logic                    bus_read,
	input  logic                    bus_write,
	input  logic                    bus_address0,
	input  io_hub_pkg::io_data_t    bus_writedata,
	input  io_hub_pkg::irq_lines_t  irq_lines,
	input  logic                    interrupt_done,
	output io_hub_pkg::io_data_t    pic_readdata,
	output logic                    interrupt_do,
	output io_hub_pkg::irq_vec_t    interrupt_vector
);
	import io_hub_pkg::*;

	irq_lines_t prev_lines;
	irq_lines_t pending;
	irq_lines_t mask;
	irq_lines_t active;
	irq_lines_t rising;
	irq_lines_t ack_bits;
	logic [2:0] irq_idx;

	assign active = pending & ~mask;
	assign rising = irq_lines & ~prev_lines;

	// line 0 wins
	always_comb begin
		irq_idx = 3'd0;
		for (int i = 7; i >= 0; i--) begin
			if (active[i]) begin
				irq_idx = i[2:0];
			end
		end
	end

	assign interrupt_do     = |active;
	assign interrupt_vector = `IO_HUB_VECTOR_BASE + {5'd0, irq_idx};
	assign ack_bits         = (interrupt_done && interrupt_do) ? irq_lines_t'(1) << irq_idx : '0;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			prev_lines <= '0;
			pending    <= '0;
			mask       <= `IO_HUB_PIC_MASK_INIT;
		end else begin
			prev_lines <= irq_lines;
			pending    <= (pending & ~ack_bits) | rising; // new edge beats ack
			if (pic_cs && bus_write && bus_address0) begin
				mask <= bus_writedata;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pic_cs && bus_read) begin
			pic_readdata <= bus_address0 ? mask : pending;
		end
	end

endmodule

// File: design/pit_timer.sv
`timescale 1ns/1ps

`include "io_hub_config.svh"

module pit_timer (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  pit_cs,
	input  logic                  bus_read,
	input  logic                  bus_write,
	input  io_hub_pkg::io_data_t  bus_writedata,
	output io_hub_pkg::io_data_t  pit_readdata,
	output logic                  pit_irq
);
	import io_hub_pkg::*;

	pit_count_t count;
	pit_count_t reload;
	io_data_t   reload_lo;  // held until the high byte arrives
	io_data_t   latch_hi;   // frozen by a low-byte read
	logic       byte_hi;    // next access hits the high byte
	logic       running;
	logic       wr_acc;
	logic       rd_acc;
	logic       tick;
	logic [`IO_HUB_PIT_PRESCALE_W-1:0] pre_cnt;

	assign wr_acc = pit_cs && bus_write;
	assign rd_acc = pit_cs && bus_read;
	assign tick   = (pre_cnt == `IO_HUB_PIT_PRESCALE_W'(`IO_HUB_PIT_PRESCALE - 1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			byte_hi <= 1'b0;
			running <= 1'b0; // idle until first reload
			count   <= '0;
			pre_cnt <= '0;
			pit_irq <= 1'b0;
		end else begin
			pit_irq <= 1'b0;
			if (wr_acc || rd_acc) begin
				byte_hi <= !byte_hi;
			end
			if (wr_acc && byte_hi) begin
				count   <= {bus_writedata, reload_lo}; // restart
				running <= 1'b1;
				pre_cnt <= '0;
			end else if (running) begin
				pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
				if (tick) begin
					if (count == 16'd1) begin
						count   <= reload; // terminal count
						pit_irq <= 1'b1;
					end else begin
						count <= count - 1'b1; // zero wraps, so reload 0 runs 65536
					end
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_acc) begin
			if (byte_hi) begin
				reload <= {bus_writedata, reload_lo};
			end else begin
				reload_lo <= bus_writedata;
			end
		end
		if (rd_acc) begin
			if (byte_hi) begin
				pit_readdata <= latch_hi;
			end else begin
				pit_readdata <= count[7:0];
				latch_hi     <= count[15:8];
			end
		end
	end

endmodule

// File: design/port_decode.sv
`timescale 1ns/1ps

`include "io_hub_config.svh"

module port_decode (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  io_hub_pkg::io_addr_t  bus_address,
	input  io_hub_pkg::io_data_t  pit_readdata,
	input  io_hub_pkg::io_data_t  pic_readdata,
	output logic                  pit_cs,
	output logic                  pic_cs,
	output io_hub_pkg::io_data_t  bus_readdata
);
	import io_hub_pkg::*;

	io_addr_t pic_window;

	// both pic ports share one select
	assign pic_window = {bus_address[15:1], 1'b0};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pit_cs <= 1'b0;
			pic_cs <= 1'b0;
		end else begin
			pit_cs <= (bus_address == `IO_HUB_PIT_PORT);
			pic_cs <= (pic_window == `IO_HUB_PIC_BASE);
		end
	end

	always_comb begin
		if (pit_cs) begin
			bus_readdata = pit_readdata;
		end else if (pic_cs) begin
			bus_readdata = pic_readdata;
		end else begin
			bus_readdata = `IO_HUB_UNMAPPED_DATA; // nobody home
		end
	end

endmodule

// File: io_hub.f
+incdir+design
design/io_hub_pkg.sv
design/io_bus_ctrl.sv
design/port_decode.sv
design/pit_timer.sv
design/pic_ctrl.sv
design/io_hub.sv
test/io_hub_properties.sv
test/io_hub_tb.sv

// File: test/io_hub_properties.sv
`timescale 1ns/1ps

`include "io_hub_config.svh"

module io_hub_properties (
	input logic                  clk_sys,
	input logic                  rst_n,
	input logic                  io_read_done,
	input logic                  io_write_done,
	input logic                  bus_read,
	input logic                  bus_write,
	input logic                  interrupt_do,
	input io_hub_pkg::irq_vec_t  interrupt_vector
);

	int prop_errors = 0; // failed property count

	read_done_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		io_read_done |=> !io_read_done)
		else begin
			prop_errors++;
			$error("io_read_done high two cycles in a row");
		end

	write_done_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		io_write_done |=> !io_write_done)
		else begin
			prop_errors++;
			$error("io_write_done high two cycles in a row");
		end

	strobes_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(bus_read && bus_write))
		else begin
			prop_errors++;
			$error("bus_read and bus_write high together");
		end

	vector_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		interrupt_do |-> (interrupt_vector >= `IO_HUB_VECTOR_BASE &&
			interrupt_vector <= `IO_HUB_VECTOR_BASE + 8'd7))
		else begin
			prop_errors++;
			$error("interrupt_vector outside the vector window");
		end

endmodule

bind io_hub io_hub_properties props_i (
	.clk_sys          (clk_sys),
	.rst_n            (rst_n),
	.io_read_done     (io_read_done),
	.io_write_done    (io_write_done),
	.bus_read         (bus_read),
	.bus_write        (bus_write),
	.interrupt_do     (interrupt_do),
	.interrupt_vector (interrupt_vector)
);

// File: test/io_hub_tb.sv
`timescale 1ns/1ps

`include "io_hub_config.svh"

module io_hub_tb;
	import io_hub_pkg::*;

	localparam int READ_LATENCY    = 3;
	localparam int PIT_RELOAD      = 20;
	localparam int WATCHDOG_CYCLES = 3000; // all tests need well under 600 cycles

	logic       clk_sys = 1'b0;
	logic       rst_n;
	logic       io_read_do;
	io_addr_t   io_read_address;
	io_data_t   io_read_data;
	logic       io_read_done;
	logic       io_write_do;
	io_addr_t   io_write_address;
	io_data_t   io_write_data;
	logic       io_write_done;
	logic [6:0] irq_ext;
	logic       interrupt_do;
	irq_vec_t   interrupt_vector;
	logic       interrupt_done;

	int          checks = 0;
	int          errors = 0;
	logic [15:0] lfsr_state = 16'd59431;

	io_hub dut_i (.*);

	always #50 clk_sys = ~clk_sys;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic io_data_t rand_byte();
		io_data_t b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			b = {b[6:0], lfsr_state[0]};
		end
		return b;
	endfunction

	task automatic check_equal(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic io_read(input io_addr_t addr, output io_data_t data, output int latency);
		int   n;
		logic got;
		n   = 0;
		got = 1'b0;
		@(posedge clk_sys);
		io_read_do      <= 1'b1;
		io_read_address <= addr;
		while (!got && n < 10) begin
			@(posedge clk_sys);
			n++;
			@(negedge clk_sys);
			got = io_read_done;
		end
		check_true(got, $sformatf("no done for read of port %h", addr));
		data    = io_read_data;
		latency = n - 1; // first edge after drive samples do
		@(posedge clk_sys);
		io_read_do <= 1'b0;
	endtask

	task automatic io_write(input io_addr_t addr, input io_data_t data);
		int   n;
		logic got;
		n   = 0;
		got = 1'b0;
		@(posedge clk_sys);
		io_write_do      <= 1'b1;
		io_write_address <= addr;
		io_write_data    <= data;
		while (!got && n < 10) begin
			@(posedge clk_sys);
			n++;
			@(negedge clk_sys);
			got = io_write_done;
		end
		check_true(got, $sformatf("no done for write of port %h", addr));
		@(posedge clk_sys);
		io_write_do <= 1'b0;
	endtask

	task automatic read_port(input io_addr_t addr, output io_data_t data);
		int latency;
		io_read(addr, data, latency);
	endtask

	// rising edge on the external lines set in bits 7:1
	task automatic pulse_lines(input irq_lines_t lines);
		@(posedge clk_sys);
		irq_ext <= lines[7:1];
		@(posedge clk_sys);
		irq_ext <= '0;
		@(posedge clk_sys);
	endtask

	task automatic ack_irq();
		@(posedge clk_sys);
		interrupt_done <= 1'b1;
		@(posedge clk_sys);
		interrupt_done <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic read_count(output pit_count_t count);
		io_data_t lo;
		io_data_t hi;
		read_port(`IO_HUB_PIT_PORT, lo);
		read_port(`IO_HUB_PIT_PORT, hi);
		count = {hi, lo};
	endtask

	task automatic test_reset_state();
		io_data_t d;
		int       latency;
		@(negedge clk_sys);
		check_equal("interrupt_do", interrupt_do, 1'b0);
		io_read(16'h0100, d, latency);
		check_equal("io_read_data", d, 8'hFF);
		check_equal("read latency", latency, READ_LATENCY);
		read_port(`IO_HUB_PIC_BASE + 16'd1, d);
		check_equal("pic mask", d, 8'hFF);
		read_port(`IO_HUB_PIC_BASE, d);
		check_equal("pic pending", d, 8'h00);
	endtask

	task automatic test_mask_access();
		io_data_t m;
		io_data_t d;
		repeat (4) begin
			m = rand_byte();
			io_write(`IO_HUB_PIC_BASE + 16'd1, m);
			read_port(`IO_HUB_PIC_BASE + 16'd1, d);
			check_equal("pic mask", d, m);
		end
		io_write(16'h0121, ~m); // unmapped, same low byte as the mask port
		read_port(`IO_HUB_PIC_BASE + 16'd1, d);
		check_equal("pic mask after unmapped write", d, m);
	endtask

	task automatic test_external_line(input int k);
		io_data_t d;
		io_write(`IO_HUB_PIC_BASE + 16'd1, 8'h00);
		pulse_lines(irq_lines_t'(1) << k);
		@(negedge clk_sys);
		check_equal("interrupt_do", interrupt_do, 1'b1);
		check_equal("interrupt_vector", interrupt_vector, 8'h08 + k);
		read_port(`IO_HUB_PIC_BASE, d);
		check_equal("pic pending", d, 8'h01 << k);
		ack_irq();
		check_equal("interrupt_do after ack", interrupt_do, 1'b0);
		read_port(`IO_HUB_PIC_BASE, d);
		check_equal("pic pending after ack", d, 8'h00);

		// masked line still latches
		io_write(`IO_HUB_PIC_BASE + 16'd1, 8'h01 << k);
		pulse_lines(irq_lines_t'(1) << k);
		@(negedge clk_sys);
		check_equal("interrupt_do while masked", interrupt_do, 1'b0);
		read_port(`IO_HUB_PIC_BASE, d);
		check_equal("pic pending while masked", d, 8'h01 << k);
		io_write(`IO_HUB_PIC_BASE + 16'd1, 8'h00);
		ack_irq(); // drain it
	endtask

	task automatic test_priority();
		io_write(`IO_HUB_PIC_BASE + 16'd1, 8'h00);
		pulse_lines(8'b0010_1000);
		@(negedge clk_sys);
		check_equal("interrupt_vector", interrupt_vector, 8'h0B);
		ack_irq();
		check_equal("interrupt_vector after ack", interrupt_vector, 8'h0D);
		ack_irq();
		check_equal("interrupt_do", interrupt_do, 1'b0);
	endtask

	task automatic test_timer_irq();
		int   n;
		logic got;
		n   = 0;
		got = 1'b0;
		io_write(`IO_HUB_PIC_BASE + 16'd1, 8'hFE);
		io_write(`IO_HUB_PIT_PORT, PIT_RELOAD[7:0]);
		io_write(`IO_HUB_PIT_PORT, PIT_RELOAD[15:8]);
		while (!got && n < PIT_RELOAD * 4 + 10) begin
			@(negedge clk_sys);
			n++;
			got = interrupt_do;
		end
		check_true(got, "timer interrupt did not arrive in time");
		check_equal("interrupt_vector", interrupt_vector, 8'h08);
		ack_irq();
	endtask

	task automatic test_timer_readback();
		pit_count_t first;
		pit_count_t second;
		io_data_t   d;
		read_count(first);
		wait_cycles(8);
		read_count(second);
		read_port(`IO_HUB_PIC_BASE, d);
		check_true(first <= PIT_RELOAD, $sformatf("first count %0d above reload", first));
		check_true(second <= PIT_RELOAD, $sformatf("second count %0d above reload", second));
		check_true(second < first || d[0], "later count not lower and no wrap flagged");
	endtask

	initial begin
		rst_n            <= 1'b0;
		io_read_do       <= 1'b0;
		io_read_address  <= '0;
		io_write_do      <= 1'b0;
		io_write_address <= '0;
		io_write_data    <= '0;
		irq_ext          <= '0;
		interrupt_done   <= 1'b0;
		wait_cycles(8);
		rst_n <= 1'b1;

		test_reset_state();
		test_mask_access();
		test_external_line(2);
		test_external_line(6);
		test_priority();
		test_timer_irq();
		test_timer_readback();

		wait_cycles(2);
		$display("Checks: %0d, check errors: %0d, property errors: %0d",
			checks, errors, dut_i.props_i.prop_errors);
		if (errors == 0 && dut_i.props_i.prop_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		wait_cycles(WATCHDOG_CYCLES);
		$display("Error: watchdog expired before the tests finished");
		$display("Errors found");
		$finish;
	end

endmodule
